//--- rtl/orao_mem_pkg.sv
package orao_mem_pkg;

   ////////////////////////////////////////
   // Memory map, region code is addr[15:13]
   ////////////////////////////////////////

   // RAM covers codes 0 up to REG_RAM
   localparam logic [2:0] REG_RAM    = 3'd2;
   localparam logic [2:0] REG_VRAM   = 3'd3;
   localparam logic [2:0] REG_IO     = 3'd4;
   // ROM mirrors over both upper regions
   localparam logic [2:0] REG_ROM_LO = 3'd6;
   localparam logic [2:0] REG_ROM_HI = 3'd7;

   // Memory sizes in bytes
   localparam int RAM_DEPTH  = 24576;
   localparam int VRAM_DEPTH = 8192;
   localparam int ROM_DEPTH  = 32;
   localparam int ROM_AW     = 5;

   // Offsets inside the I/O page (addr[12:0])
   // Eight keyboard rows from KBD_OFS
   localparam logic [12:0] KBD_OFS  = 13'h0800;
   localparam logic [12:0] SPK_OFS  = 13'h0840;
   localparam logic [12:0] CTRL_OFS = 13'h0880;

endpackage

//--- rtl/orao_video_pkg.sv
package orao_video_pkg;

   ////////////////////////////////////////
   // Raster timing, in pixel clocks
   ////////////////////////////////////////

   localparam int H_ACTIVE = 256;
   localparam int H_FRONT  = 16;
   localparam int H_SYNC   = 32;
   localparam int H_BACK   = 16;
   localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

   // Vertical timing, in lines
   localparam int V_ACTIVE = 256;
   localparam int V_FRONT  = 4;
   localparam int V_SYNC   = 4;
   localparam int V_BACK   = 16;
   localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   // Display geometry
   // One byte holds 8 pixels, 32 bytes per line
   localparam int BYTES_PER_ROW = 32;
   localparam int VRAM_AW       = 13;

endpackage

//--- rtl/orao_ram.sv
`timescale 1ns/1ps

module orao_ram #(
   parameter int DEPTH = 8192
) (
   input  logic                     clk,
   // Port a, CPU side
   input  logic [$clog2(DEPTH)-1:0] addr_a,
   input  logic [7:0]               din_a,
   input  logic                     we_a,
   output logic [7:0]               q_a,
   // Port b, read only
   input  logic [$clog2(DEPTH)-1:0] addr_b,
   output logic [7:0]               q_b
);

   // Byte storage
   logic [7:0] mem [DEPTH];

   ////////////////////////////////////////
   // Port a
   ////////////////////////////////////////

   // Registered read returns old data on a same-edge write
   always_ff @(posedge clk) begin
      if (we_a) begin
         mem[addr_a] <= din_a;
      end
      q_a <= mem[addr_a];
   end

   ////////////////////////////////////////
   // Port b
   ////////////////////////////////////////

   // Scanner fetch, one cycle latency
   always_ff @(posedge clk) begin
      q_b <= mem[addr_b];
   end

endmodule

//--- rtl/orao_rom.sv
`timescale 1ns/1ps

module orao_rom import orao_mem_pkg::*; (
   input  logic              clk,
   input  logic [ROM_AW-1:0] addr,
   output logic [7:0]        q
);

   // ROM image, 32 bytes
   logic [7:0] mem [ROM_DEPTH];

   // Contents come from the hex file
   initial begin
      $readmemh("rom.hex", mem);
   end

   // Only the low address bits reach here
   // so the image repeats over C000-FFFF
   always_ff @(posedge clk) begin
      q <= mem[addr];
   end

endmodule

//--- rtl/orao_video.sv
`timescale 1ns/1ps

module orao_video import orao_video_pkg::*; (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               video_blank,
   // Video RAM port b
   output logic [VRAM_AW-1:0] vram_addr,
   input  logic [7:0]         vram_data,
   // Raster outputs
   output logic               pix,
   output logic               hsync,
   output logic               vsync,
   output logic               hblank,
   output logic               vblank,
   output logic               de
);

   // Raster position
   logic [8:0] hcnt;
   logic [8:0] vcnt;
   // Flags decoded from the counters
   logic       hs_c;
   logic       vs_c;
   logic       hb_c;
   logic       vb_c;
   // First delay stage
   logic       hs_d1;
   logic       vs_d1;
   logic       hb_d1;
   logic       vb_d1;
   logic       load_d1;
   // Pixel shifter
   logic [7:0] shift;

   ////////////////////////////////////////
   // Counters
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hcnt <= '0;
         vcnt <= '0;
      end else if (hcnt == 9'(H_TOTAL - 1)) begin
         hcnt <= '0;
         // End of line, step or wrap the line count
         if (vcnt == 9'(V_TOTAL - 1)) begin
            vcnt <= '0;
         end else begin
            vcnt <= vcnt + 1'b1;
         end
      end else begin
         hcnt <= hcnt + 1'b1;
      end
   end

   // Sync windows start after the front porch
   assign hs_c = (hcnt >= 9'(H_ACTIVE + H_FRONT)) && (hcnt < 9'(H_ACTIVE + H_FRONT + H_SYNC));
   assign vs_c = (vcnt >= 9'(V_ACTIVE + V_FRONT)) && (vcnt < 9'(V_ACTIVE + V_FRONT + V_SYNC));
   assign hb_c = hcnt >= 9'(H_ACTIVE);
   assign vb_c = vcnt >= 9'(V_ACTIVE);

   // Byte of the current 8-pixel group
   // data is back on vram_data one cycle later
   assign vram_addr = VRAM_AW'(vcnt[7:0] * BYTES_PER_ROW) + VRAM_AW'(hcnt[7:3]);

   ////////////////////////////////////////
   // Two-stage flag delay
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hs_d1   <= 1'b0;
         vs_d1   <= 1'b0;
         hb_d1   <= 1'b0;
         vb_d1   <= 1'b0;
         load_d1 <= 1'b0;
         hsync   <= 1'b0;
         vsync   <= 1'b0;
         hblank  <= 1'b0;
         vblank  <= 1'b0;
         de      <= 1'b0;
      end else begin
         hs_d1   <= hs_c;
         vs_d1   <= vs_c;
         hb_d1   <= hb_c;
         vb_d1   <= vb_c;
         // Group start, fetched byte arrives next cycle
         load_d1 <= hcnt[2:0] == 3'd0;
         hsync   <= hs_d1;
         vsync   <= vs_d1;
         hblank  <= hb_d1;
         vblank  <= vb_d1;
         de      <= !(hb_d1 || vb_d1);
      end
   end

   ////////////////////////////////////////
   // Pixel shifter
   ////////////////////////////////////////

   // New byte while the last bit of the previous one leaves
   // LSB is the leftmost pixel
   always_ff @(posedge clk) begin
      if (load_d1) begin
         shift <= vram_data;
      end else begin
         shift <= {1'b0, shift[7:1]};
      end
   end

   // Dark outside the active area or when blanked
   assign pix = shift[0] && de && !video_blank;

endmodule

//--- rtl/orao_io.sv
`timescale 1ns/1ps

module orao_io import orao_mem_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        ce,
   // CPU bus, we already qualified by region
   input  logic [15:0] addr,
   input  logic [7:0]  data_in,
   input  logic        we,
   output logic [7:0]  data_out,
   // Keyboard events
   input  logic [10:0] ps2_key,
   // To the scanner and the speaker
   output logic        video_blank,
   output logic        audio
);

   // Key matrix, active low, row then column
   logic [7:0][7:0] kbd;
   // Last seen event toggle
   logic            key_tgl_q;
   logic [2:0]      key_row;
   logic [2:0]      key_col;
   // Control register, bit 0 blanks the screen
   logic [7:0]      ctrl;

   ////////////////////////////////////////
   // Keyboard matrix
   ////////////////////////////////////////

   // Row and column straight from the code bits
   assign key_row = ps2_key[5:3];
   assign key_col = ps2_key[2:0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         kbd       <= '1;
         key_tgl_q <= 1'b0;
      end else begin
         key_tgl_q <= ps2_key[10];
         // New event when bit 10 flips
         // press pulls the bit low
         if (ps2_key[10] != key_tgl_q) begin
            kbd[key_row][key_col] <= !ps2_key[9];
         end
      end
   end

   ////////////////////////////////////////
   // Speaker and control writes
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         audio <= 1'b0;
         ctrl  <= '0;
      end else if (we && ce) begin
         if (addr[12:0] == SPK_OFS) begin
            audio <= !audio;
         end
         if (addr[12:0] == CTRL_OFS) begin
            ctrl <= data_in;
         end
      end
   end

   assign video_blank = ctrl[0];

   // Registered read, one cycle from addr
   // unmapped offsets read FF
   always_ff @(posedge clk) begin
      if (addr[12:3] == KBD_OFS[12:3]) begin
         data_out <= kbd[addr[2:0]];
      end else if (addr[12:0] == CTRL_OFS) begin
         data_out <= ctrl;
      end else begin
         data_out <= 8'hff;
      end
   end

endmodule

//--- rtl/orao_hw.sv
`timescale 1ns/1ps

module orao_hw import orao_mem_pkg::*, orao_video_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        ce_1m,
   // CPU bus
   input  logic [15:0] addr,
   input  logic [7:0]  data_in,
   input  logic        we,
   output logic [7:0]  data_out,
   // Video
   output logic        pix,
   output logic        hsync,
   output logic        vsync,
   output logic        hblank,
   output logic        vblank,
   output logic        de,
   // Keyboard and speaker
   input  logic [10:0] ps2_key,
   output logic        audio
);

   // Region from the top address bits
   logic [2:0]         region;
   logic               ram_we;
   logic               vram_we;
   logic               io_we;
   // RAM is 24K, wrap the address into it
   logic [14:0]        ram_addr;
   // Registered read sources
   logic [7:0]         rom_data;
   logic [7:0]         ram_data;
   logic [7:0]         vram_data;
   logic [7:0]         io_data;
   // Scanner side of the video RAM
   logic [VRAM_AW-1:0] video_addr;
   logic [7:0]         video_data;
   logic               video_blank;

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   assign region   = addr[15:13];
   assign ram_we   = we && (region <= REG_RAM);
   assign vram_we  = we && (region == REG_VRAM);
   // ce_1m applied inside the I/O block
   assign io_we    = we && (region == REG_IO);
   assign ram_addr = 15'(addr % 16'(RAM_DEPTH));

   ////////////////////////////////////////
   // Memories
   ////////////////////////////////////////

   orao_rom rom (
      .clk  (clk),
      .addr (addr[ROM_AW-1:0]),
      .q    (rom_data)
   );

   // Second port of the main RAM stays idle
   orao_ram #(.DEPTH(RAM_DEPTH)) ram (
      .clk    (clk),
      .addr_a (ram_addr),
      .din_a  (data_in),
      .we_a   (ram_we),
      .q_a    (ram_data),
      .addr_b ('0),
      .q_b    ()
   );

   orao_ram #(.DEPTH(VRAM_DEPTH)) vram (
      .clk    (clk),
      .addr_a (addr[VRAM_AW-1:0]),
      .din_a  (data_in),
      .we_a   (vram_we),
      .q_a    (vram_data),
      .addr_b (video_addr),
      .q_b    (video_data)
   );

   ////////////////////////////////////////
   // Scanner and I/O page
   ////////////////////////////////////////

   orao_video video (
      .clk         (clk),
      .arst_n      (arst_n),
      .video_blank (video_blank),
      .vram_addr   (video_addr),
      .vram_data   (video_data),
      .pix         (pix),
      .hsync       (hsync),
      .vsync       (vsync),
      .hblank      (hblank),
      .vblank      (vblank),
      .de          (de)
   );

   orao_io io (
      .clk         (clk),
      .arst_n      (arst_n),
      .ce          (ce_1m),
      .addr        (addr),
      .data_in     (data_in),
      .we          (io_we),
      .data_out    (io_data),
      .ps2_key     (ps2_key),
      .video_blank (video_blank),
      .audio       (audio)
   );

   // Read mux on the current region
   // A000-BFFF falls through to RAM
   always_comb begin
      case (region)
         REG_ROM_LO,
         REG_ROM_HI: data_out = rom_data;
         REG_IO:     data_out = io_data;
         REG_VRAM:   data_out = vram_data;
         default:    data_out = ram_data;
      endcase
   end

endmodule

//--- verification/orao_chk.sv
`timescale 1ns/1ps

module orao_chk import orao_mem_pkg::*, orao_video_pkg::*; (
   input logic        clk,
   input logic        arst_n,
   input logic        ce_1m,
   input logic [15:0] addr,
   input logic [7:0]  data_in,
   input logic        we,
   input logic [7:0]  data_out,
   input logic        pix,
   input logic        hsync,
   input logic        vsync,
   input logic        hblank,
   input logic        vblank,
   input logic        de,
   input logic [10:0] ps2_key,
   input logic        audio
);

   // Shadow state built from port activity
   logic [7:0]      ram_sh [RAM_DEPTH];
   logic [7:0]      vram_sh [VRAM_DEPTH];
   logic [7:0]      rom_sh [ROM_DEPTH];
   logic [7:0][7:0] key_sh;
   logic [7:0]      ctrl_sh;
   logic            aud_sh;
   logic            tgl_q;
   logic [14:0]     ram_idx;
   logic [7:0]      rd_exp;
   // Counted raster position and expected pixel pipe
   logic [8:0]      x;
   logic [8:0]      y;
   logic [1:0]      pix_d;
   logic [1:0]      run_d;
   logic [5:0]      hs_len;
   // Expected hsync, vsync, hblank and vblank in that order
   logic [3:0]      flags_now;
   logic [1:0][3:0] flags_d;
   // First failure for the testbench to pick up
   logic            err_seen = 1'b0;
   logic            err_value;
   string           err_sig;
   string           err_msg;
   logic [7:0]      err_exp;
   logic [7:0]      err_act;
   time             err_time;

   initial begin
      $readmemh("rom.hex", rom_sh);
   end

   task automatic record_mismatch(input string sig, input logic [7:0] exp_v,
                                  input logic [7:0] act_v);
      if (!err_seen) begin
         err_value = 1'b1;
         err_sig   = sig;
         err_exp   = exp_v;
         err_act   = act_v;
         err_time  = $time;
         err_seen  = 1'b1;
      end
   endtask

   task automatic record_fault(input string msg);
      if (!err_seen) begin
         err_value = 1'b0;
         err_msg   = msg;
         err_time  = $time;
         err_seen  = 1'b1;
      end
   endtask

   ////////////////////////////////////////
   // Shadow memories and registers
   ////////////////////////////////////////

   // 24K RAM wraps so A000-BFFF lands on its upper part
   assign ram_idx = 15'(addr % 16'(RAM_DEPTH));

   always_ff @(posedge clk) begin
      if (we && addr[15:13] <= REG_RAM) begin
         ram_sh[ram_idx] <= data_in;
      end
      if (we && addr[15:13] == REG_VRAM) begin
         vram_sh[addr[12:0]] <= data_in;
      end
      // Expected read data keeps old contents on a same-edge write
      case (addr[15:13])
         REG_ROM_LO, REG_ROM_HI: rd_exp <= rom_sh[addr[ROM_AW-1:0]];
         REG_VRAM:               rd_exp <= vram_sh[addr[12:0]];
         REG_IO: begin
            if (addr[12:3] == KBD_OFS[12:3]) begin
               rd_exp <= key_sh[addr[2:0]];
            end else if (addr[12:0] == CTRL_OFS) begin
               rd_exp <= ctrl_sh;
            end else begin
               rd_exp <= 8'hff;
            end
         end
         default:                rd_exp <= ram_sh[ram_idx];
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         key_sh  <= '1;
         ctrl_sh <= '0;
         aud_sh  <= 1'b0;
         tgl_q   <= 1'b0;
      end else begin
         tgl_q <= ps2_key[10];
         // A key event pulls the bit low on press
         if (ps2_key[10] != tgl_q) begin
            key_sh[ps2_key[5:3]][ps2_key[2:0]] <= !ps2_key[9];
         end
         if (we && ce_1m && addr[15:13] == REG_IO) begin
            if (addr[12:0] == SPK_OFS) begin
               aud_sh <= !aud_sh;
            end
            if (addr[12:0] == CTRL_OFS) begin
               ctrl_sh <= data_in;
            end
         end
      end
   end

   ////////////////////////////////////////
   // Raster model
   ////////////////////////////////////////

   // Sync windows follow the front porch
   assign flags_now[3] = (x >= 9'(H_ACTIVE + H_FRONT)) &&
                         (x < 9'(H_ACTIVE + H_FRONT + H_SYNC));
   assign flags_now[2] = (y >= 9'(V_ACTIVE + V_FRONT)) &&
                         (y < 9'(V_ACTIVE + V_FRONT + V_SYNC));
   assign flags_now[1] = x >= 9'(H_ACTIVE);
   assign flags_now[0] = y >= 9'(V_ACTIVE);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         x       <= '0;
         y       <= '0;
         run_d   <= '0;
         hs_len  <= '0;
         flags_d <= '0;
      end else begin
         x <= (x == 9'(H_TOTAL - 1)) ? '0 : x + 9'd1;
         if (x == 9'(H_TOTAL - 1)) begin
            y <= (y == 9'(V_TOTAL - 1)) ? '0 : y + 9'd1;
         end
         // Outputs trail the counters by two clocks
         run_d   <= {run_d[0], 1'b1};
         flags_d <= {flags_d[0], flags_now};
         hs_len  <= hsync ? hs_len + 6'd1 : '0;
      end
   end

   // Byte y*32 + x/8 with the leftmost pixel in bit 0
   always_ff @(posedge clk) begin
      pix_d <= {pix_d[0], (x < 9'(H_ACTIVE)) && (y < 9'(V_ACTIVE)) &&
                          vram_sh[{y[7:0], x[7:3]}][x[2:0]]};
   end

   ////////////////////////////////////////
   // Assertions
   ////////////////////////////////////////

   // Second cycle of a stable read
   a_read: assert property (@(posedge clk) disable iff (!arst_n)
      (!$past(we) && addr == $past(addr)) |-> data_out == rd_exp)
      else begin
         record_mismatch("data_out", $sampled(rd_exp), $sampled(data_out));
         $error("data_out differs from shadow");
      end

   a_audio: assert property (@(posedge clk) disable iff (!arst_n) audio == aud_sh)
      else begin
         record_mismatch("audio", 8'($sampled(aud_sh)), 8'($sampled(audio)));
         $error("audio differs from shadow");
      end

   a_de: assert property (@(posedge clk) disable iff (!arst_n)
      run_d[1] |-> de == !(hblank || vblank))
      else begin
         record_fault("de is not the inverse of hblank or vblank");
         $error("de rule broken");
      end

   // Sync and blank flags at the counted raster position
   a_flags: assert property (@(posedge clk) disable iff (!arst_n)
      run_d[1] |-> {hsync, vsync, hblank, vblank} == flags_d[1])
      else begin
         record_mismatch("hsync vsync hblank vblank", 8'($sampled(flags_d[1])),
                         8'($sampled({hsync, vsync, hblank, vblank})));
         $error("sync or blank flags differ from raster position");
      end

   a_hsync: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(hsync) |-> hs_len == 6'(H_SYNC))
      else begin
         record_mismatch("hsync pulse length", 8'(H_SYNC), 8'($sampled(hs_len)));
         $error("hsync pulse length wrong");
      end

   // Blank acts at once on the output
   a_pix: assert property (@(posedge clk) disable iff (!arst_n)
      run_d[1] |-> pix == (pix_d[1] && !ctrl_sh[0]))
      else begin
         record_mismatch("pix", 8'($sampled(pix_d[1] && !ctrl_sh[0])),
                         8'($sampled(pix)));
         $error("pix differs from video RAM shadow");
      end

endmodule

//--- verification/orao_tb.sv
`timescale 1ns/1ps

module orao_tb import orao_mem_pkg::*, orao_video_pkg::*; ();

   // Three frames cover the video checks, the rest is bus traffic
   localparam int MAX_CYCLES = 3 * H_TOTAL * V_TOTAL + 4000;
   // Bus rests on the ROM when idle
   localparam logic [15:0] IDLE_ADDR = 16'hc000;
   localparam logic [15:0] SPK_ADDR  = {REG_IO, SPK_OFS};
   localparam logic [15:0] CTRL_ADDR = {REG_IO, CTRL_OFS};

   logic        clk = 1'b0;
   logic        arst_n;
   logic        ce_1m;
   logic [15:0] addr;
   logic [7:0]  data_in;
   logic        we;
   logic [7:0]  data_out;
   logic        pix;
   logic        hsync;
   logic        vsync;
   logic        hblank;
   logic        vblank;
   logic        de;
   logic [10:0] ps2_key;
   logic        audio;
   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   logic [31:0] lfsr = 32'h74d6;
   int          cycles = 0;

   orao_hw DUT (.*);

   bind orao_hw orao_chk chk (.*);

   always #2 clk = !clk;

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      end
   endtask

   // we high for one edge, ce_1m given per access
   task automatic bus_write(input logic [15:0] a, input logic [7:0] d, input logic ce);
      @(negedge clk);
      addr    = a;
      data_in = d;
      we      = 1'b1;
      ce_1m   = ce;
      @(negedge clk);
      we    = 1'b0;
      ce_1m = 1'b1;
   endtask

   // addr held two cycles, checked on the second
   task automatic bus_read(input logic [15:0] a);
      @(negedge clk);
      addr = a;
      we   = 1'b0;
      @(negedge clk);
   endtask

   task automatic bus_idle();
      @(negedge clk);
      addr = IDLE_ADDR;
      we   = 1'b0;
   endtask

   task automatic key_event(input logic press, input logic [5:0] code);
      @(negedge clk);
      ps2_key = {!ps2_key[10], press, 3'b000, code};
   endtask

   ////////////////////////////////////////
   // Failure watch and timeout
   ////////////////////////////////////////

   always @(negedge clk) begin
      if (DUT.chk.err_seen) begin
         if (DUT.chk.err_value) begin
            $display("ERR %0t %s expected %h actual %h", DUT.chk.err_time,
                     DUT.chk.err_sig, DUT.chk.err_exp, DUT.chk.err_act);
         end else begin
            $display("Check failed at %0t: %s", DUT.chk.err_time, DUT.chk.err_msg);
         end
         $display("TEST FAIL");
         $fatal(1, "Stopped at first failing check");
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAIL");
         $fatal(1, "Stopped on timeout");
      end
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      logic [31:0] r;
      logic [31:0] d;
      logic [15:0] a;
      $timeformat(-9, 1, " ns", 0);
      arst_n  = 1'b0;
      ce_1m   = 1'b1;
      addr    = IDLE_ADDR;
      data_in = '0;
      we      = 1'b0;
      ps2_key = '0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      // Blank while video RAM is still unknown
      bus_write(CTRL_ADDR, 8'h01, 1'b1);
      // RAM and video RAM read after write
      repeat (64) begin
         take_bits(16, r);
         take_bits(8, d);
         a = r[15] ? {REG_VRAM, r[12:0]} : 16'(r[14:0] % 15'(RAM_DEPTH));
         bus_write(a, d[7:0], 1'b1);
         bus_read(a);
      end
      // ROM mirror, writes there must not stick
      repeat (32) begin
         take_bits(14, r);
         take_bits(8, d);
         a = {2'b11, r[13:0]};
         bus_write(a, d[7:0], 1'b1);
         bus_read(a);
      end
      // Key batches, then all eight rows
      repeat (6) begin
         repeat (8) begin
            take_bits(7, r);
            key_event(r[6], r[5:0]);
         end
         for (int row = 0; row < 8; row++) begin
            bus_read({REG_IO, KBD_OFS + 13'(row)});
         end
      end
      // Speaker toggles only with ce_1m
      bus_write(SPK_ADDR, 8'h00, 1'b1);
      bus_write(SPK_ADDR, 8'h00, 1'b0);
      bus_write(SPK_ADDR, 8'h00, 1'b1);
      // Control readback, blank bit kept on
      repeat (4) begin
         take_bits(8, d);
         bus_write(CTRL_ADDR, d[7:0] | 8'h01, 1'b1);
         bus_read(CTRL_ADDR);
      end
      bus_write(CTRL_ADDR, 8'h00, 1'b0);
      bus_read(CTRL_ADDR);
      // Random picture in the whole video RAM
      for (int i = 0; i < VRAM_DEPTH; i++) begin
         take_bits(8, d);
         bus_write({REG_VRAM, 13'(i)}, d[7:0], 1'b1);
      end
      bus_write(CTRL_ADDR, 8'h00, 1'b1);
      bus_idle();
      // One complete frame between two vsync pulses
      @(posedge vsync);
      @(posedge vsync);
      // Blank again, pix must stay low
      bus_write(CTRL_ADDR, 8'h01, 1'b1);
      bus_idle();
      repeat (16) @(posedge hsync);
      @(negedge clk);
      if (DUT.chk.err_seen) begin
         $display("A check failed before the end of the run");
         $display("TEST FAIL");
         $fatal(1, "Run ended with a failed check");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

//--- files.f
rtl/orao_mem_pkg.sv
rtl/orao_video_pkg.sv
rtl/orao_ram.sv
rtl/orao_rom.sv
rtl/orao_video.sv
rtl/orao_io.sv
rtl/orao_hw.sv
verification/orao_chk.sv
verification/orao_tb.sv

//--- Makefile
# Verilator build and run for the orao_hw testbench
TOP = orao_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

//--- rom.hex
// ROM image, one byte per line, address 0 first
a9
00
8d
80
88
a2
07
bd
00
88
9d
00
60
ca
10
f7
4c
00
c0
ea
3e
5a
c3
17
f0
2b
69
d4
81
e5
fc
ff
